// ==== filelist.f ====
verilog/burst_pkg.sv
verilog/stream_fifo.sv
verilog/mem_to_stream.sv
verilog/burst_reader.sv
verilog/sram_bank.sv
verilog/burst_reducer.sv
verilog/burst_read_top.sv
tb/burst_read_properties.sv
tb/burst_read_tb.sv

// ==== Bender.yml ====
package:
  name: burst_read

sources:
  - verilog/burst_pkg.sv
  - verilog/stream_fifo.sv
  - verilog/mem_to_stream.sv
  - verilog/burst_reader.sv
  - verilog/sram_bank.sv
  - verilog/burst_reducer.sv
  - verilog/burst_read_top.sv
  - target: test
    files:
      - tb/burst_read_properties.sv
      - tb/burst_read_tb.sv

// ==== tb/burst_read_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Inputs change 10 ns after the rising edge, outputs are sampled on the falling edge
// Writes in the read test only touch addresses outside the running burst
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module burst_read_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import burst_pkg::*;

  logic                 clk;
  logic                 rst_n;
  burst_cmd_t           cmd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  wr_req_t              wr;
  logic                 wr_valid;
  burst_result_t        result;
  logic                 result_valid;
  logic                 result_ready;
  // Mirror of the memory contents as the DUT should hold them
  logic [DataWidth-1:0] shadow_mem [256];
  // Expected results in command order
  burst_result_t        exp_q [$];
  int unsigned          queued_words;
  int unsigned          cycle_cnt;
  logic                 bp_enable;
  int unsigned          stretch;

  burst_read_top dut_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cmd_i          (cmd),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .wr_i           (wr),
    .wr_valid_i     (wr_valid),
    .result_o       (result),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready)
  );

  // Expected burst result straight from the opcode definitions
  function automatic burst_result_t ref_result(input burst_cmd_t c,
                                               input logic [DataWidth-1:0] mem [256]);
    burst_result_t        r;
    logic [AddrWidth-1:0] a;
    logic [DataWidth-1:0] w;
    r.op    = c.op;
    r.value = mem[c.base];
    r.count = CountWidth'(c.len_m1) + 1'b1;
    a       = c.base;
    for (int i = 0; i < int'(c.len_m1); i++) begin
      // Eight-bit address rolls over from 255 to 0
      a = a + 1'b1;
      w = mem[a];
      case (c.op)
        OP_SUM:  r.value = r.value + w;
        OP_XOR:  r.value = r.value ^ w;
        default: r.value = (w > r.value) ? w : r.value;
      endcase
    end
    return r;
  endfunction

  function automatic burst_cmd_t random_cmd(input int unsigned max_len_m1);
    burst_cmd_t c;
    c.op     = burst_op_e'($urandom_range(0, 2));
    c.base   = AddrWidth'($urandom_range(0, 255));
    c.len_m1 = LenWidth'($urandom_range(0, max_len_m1));
    return c;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  // Move to the drive point of the next cycle
  task automatic step_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic write_word(input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data);
    wr              = '{addr: addr, data: data};
    wr_valid        = 1'b1;
    shadow_mem[addr] = data;
    step_cycle();
    wr_valid = 1'b0;
  endtask

  // Holds the command until the DUT takes it and records the expected result
  task automatic send_cmd(input burst_cmd_t c);
    logic accepted;
    cmd       = c;
    cmd_valid = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = cmd_ready;
      if (accepted) begin
        exp_q.push_back(ref_result(c, shadow_mem));
        queued_words += int'(c.len_m1) + 1;
      end
      step_cycle();
    end
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      step_cycle();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Result back-pressure, random stretches of high and low when enabled
  initial begin
    forever begin
      step_cycle();
      if (!bp_enable) begin
        result_ready = 1'b1;
      end else if (stretch == 0) begin
        result_ready = 1'(  $urandom_range(0, 1));
        stretch      = $urandom_range(1, 24);
      end else begin
        stretch--;
      end
    end
  end

  // Compares every result handshake with the oldest expected entry
  initial begin
    burst_result_t exp;
    forever begin
      @(negedge clk);
      if (rst_n && result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("A result arrived while no command was outstanding");
        end else begin
          exp = exp_q.pop_front();
          check_value("result_o.op", 64'(result.op), 64'(exp.op));
          check_value("result_o.value", 64'(result.value), 64'(exp.value));
          check_value("result_o.count", 64'(result.count), 64'(exp.count));
        end
      end
    end
  end

  // Adapter handshake assertions end the run at the first failure
  initial begin
    forever begin
      @(negedge clk);
      if (dut_i.i_adapter.i_props.fail_cnt != 0) begin
        abort_run("An assertion on the adapter handshakes failed");
      end
    end
  end

  // Limit grows by 200 cycles for every word queued so far
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt <= 200 * queued_words + 2000) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Watchdog expired after %0d cycles with %0d results missing",
             cycle_cnt, exp_q.size());
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation timed out");
  end

  initial begin
    void'($urandom(81));
    rst_n        = 1'b0;
    cmd          = '0;
    cmd_valid    = 1'b0;
    wr           = '0;
    wr_valid     = 1'b0;
    result_ready = 1'b1;
    bp_enable    = 1'b0;
    stretch      = 0;
    queued_words = 0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;
    check_value("cmd_ready_o", 64'(cmd_ready), 64'd1);
    check_value("result_valid_o", 64'(result_valid), 64'd0);

    // Preload every word with random data
    for (int a = 0; a < 256; a++) begin
      write_word(AddrWidth'(a), $urandom());
    end

    // Single-word bursts give back the word itself
    for (int op = 0; op < 3; op++) begin
      send_cmd('{op: burst_op_e'(op), base: AddrWidth'($urandom_range(0, 255)), len_m1: '0});
    end
    wait_drain();

    // Full bursts, the last two start near the top and wrap
    send_cmd('{op: OP_SUM, base: 8'd0, len_m1: 8'd255});
    send_cmd('{op: OP_XOR, base: 8'd250, len_m1: 8'd255});
    send_cmd('{op: OP_MAX, base: 8'd255, len_m1: 8'd255});
    wait_drain();

    // Random stalls on the result side
    bp_enable = 1'b1;
    for (int n = 0; n < 10; n++) begin
      send_cmd(random_cmd(31));
    end
    wait_drain();
    bp_enable = 1'b0;

    // Writes to the upper region while the lower region is read
    send_cmd('{op: OP_SUM, base: 8'd0, len_m1: 8'd63});
    for (int k = 0; k < 40; k++) begin
      write_word(AddrWidth'(128 + $urandom_range(0, 63)), $urandom());
      if ($urandom_range(0, 1) == 1) begin
        step_cycle();
      end
    end
    wait_drain();
    // Read back the written region to see the new contents
    for (int op = 0; op < 3; op++) begin
      send_cmd('{op: burst_op_e'(op), base: 8'd128, len_m1: 8'd63});
    end
    wait_drain();

    // Back-to-back random commands
    for (int n = 0; n < 40; n++) begin
      send_cmd(random_cmd(255));
    end
    wait_drain();

    // Assertions that fired in the last cycle count as well
    if (dut_i.i_adapter.i_props.fail_cnt != 0) begin
      abort_run("An assertion on the adapter handshakes failed");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/burst_read_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bound into every mem_to_stream instance
// All checks are off while reset is low
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module burst_read_properties (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input burst_pkg::mem_req_t  mem_req_i,
  input logic                 mem_req_valid_i,
  input logic                 mem_gnt_i,
  input logic                 buf_ready_i,
  input burst_pkg::mem_resp_t resp_i,
  input logic                 resp_valid_i,
  input logic                 resp_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  // A request that the memory does not grant stays on the port unchanged
  hold_ungranted_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_i && !mem_gnt_i |=> mem_req_valid_i && $stable(mem_req_i))
    else begin
      fail_cnt++;
      $error("Ungranted memory request changed or dropped");
    end

  // A granted read always finds a free slot when its data comes back
  no_overflow_on_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_i && mem_gnt_i |=> buf_ready_i)
    else begin
      fail_cnt++;
      $error("Response buffer full when granted read data returned");
    end

  // A stalled response beat holds until the reducer takes it
  hold_stalled_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
    else begin
      fail_cnt++;
      $error("Response beat dropped or changed before it was accepted");
    end

endmodule

bind mem_to_stream burst_read_properties i_props (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .mem_req_i       (mem_req_o),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_gnt_i       (mem_gnt_i),
  .buf_ready_i     (buf_ready),
  .resp_i          (resp_o),
  .resp_valid_i    (resp_valid_o),
  .resp_ready_i    (resp_ready_i)
);

`default_nettype wire

// ==== verilog/burst_read_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Memory must be preloaded before it is read
// Results come back in command order, one per command
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module burst_read_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  burst_pkg::burst_cmd_t    cmd_i,
  input  logic                     cmd_valid_i,
  output logic                     cmd_ready_o,
  input  burst_pkg::wr_req_t       wr_i,
  input  logic                     wr_valid_i,
  output burst_pkg::burst_result_t result_o,
  output logic                     result_valid_o,
  input  logic                     result_ready_i
);
  import burst_pkg::*;

  // Reader to adapter
  mem_req_t  rd_req;
  logic      rd_req_valid;
  logic      rd_req_ready;
  // Adapter to memory and back
  mem_req_t  mem_req;
  logic      mem_req_valid;
  logic      mem_gnt;
  mem_resp_t mem_resp;
  logic      mem_resp_valid;
  // Buffered beats to the reducer
  mem_resp_t beat;
  logic      beat_valid;
  logic      beat_ready;

  burst_reader i_reader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .req_o       (rd_req),
    .req_valid_o (rd_req_valid),
    .req_ready_i (rd_req_ready)
  );

  mem_to_stream i_adapter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (rd_req),
    .req_valid_i      (rd_req_valid),
    .req_ready_o      (rd_req_ready),
    .resp_o           (beat),
    .resp_valid_o     (beat_valid),
    .resp_ready_i     (beat_ready),
    .mem_req_o        (mem_req),
    .mem_req_valid_o  (mem_req_valid),
    .mem_gnt_i        (mem_gnt),
    .mem_resp_i       (mem_resp),
    .mem_resp_valid_i (mem_resp_valid)
  );

  sram_bank i_sram (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (mem_req),
    .req_valid_i  (mem_req_valid),
    .gnt_o        (mem_gnt),
    .resp_o       (mem_resp),
    .resp_valid_o (mem_resp_valid),
    .wr_i         (wr_i),
    .wr_valid_i   (wr_valid_i)
  );

  burst_reducer i_reducer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .resp_i         (beat),
    .resp_valid_i   (beat_valid),
    .resp_ready_o   (beat_ready),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

// ==== verilog/burst_reducer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Beats must arrive in burst order with last on the final word
// Input stalls while a finished result waits for the consumer
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module burst_reducer (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  burst_pkg::mem_resp_t     resp_i,
  input  logic                     resp_valid_i,
  output logic                     resp_ready_o,
  output burst_pkg::burst_result_t result_o,
  output logic                     result_valid_o,
  input  logic                     result_ready_i
);
  import burst_pkg::*;

  logic [DataWidth-1:0]  acc_q;
  logic [CountWidth-1:0] cnt_q;
  // Next beat opens a new burst
  logic                  first_q;
  burst_result_t         result_q;
  logic                  result_valid_q;
  logic [DataWidth-1:0]  fold_value;
  logic [CountWidth-1:0] fold_count;
  logic                  beat_fire;

  assign resp_ready_o = ~result_valid_q;
  assign beat_fire    = resp_valid_i & resp_ready_o;

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

  // Fold the incoming word into the running value
  always_comb begin
    fold_value = resp_i.data;
    fold_count = CountWidth'(1);
    // The first beat seeds the accumulator whatever the op
    if (!first_q) begin
      fold_count = cnt_q + 1'b1;
      case (resp_i.op)
        OP_SUM:  fold_value = acc_q + resp_i.data;
        OP_XOR:  fold_value = acc_q ^ resp_i.data;
        OP_MAX:  fold_value = (resp_i.data > acc_q) ? resp_i.data : acc_q;
        default: fold_value = resp_i.data;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      first_q        <= 1'b1;
      result_valid_q <= 1'b0;
    end else begin
      if (beat_fire) begin
        first_q <= resp_i.last;
      end
      if (beat_fire && resp_i.last) begin
        result_valid_q <= 1'b1;
      end else if (result_valid_q && result_ready_i) begin
        result_valid_q <= 1'b0;
      end
    end
  end

  // Accumulator, count and result are payload
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      acc_q <= fold_value;
      cnt_q <= fold_count;
      if (resp_i.last) begin
        result_q <= '{op: resp_i.op, value: fold_value, count: fold_count};
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sram_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Single-port 256-word memory, read data one cycle after grant
// A preload write owns the port and withdraws the read grant
// Memory contents are undefined until written
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module sram_bank (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  burst_pkg::mem_req_t  req_i,
  input  logic                 req_valid_i,
  output logic                 gnt_o,
  output burst_pkg::mem_resp_t resp_o,
  output logic                 resp_valid_o,
  input  burst_pkg::wr_req_t   wr_i,
  input  logic                 wr_valid_i
);
  import burst_pkg::*;

  logic [DataWidth-1:0] mem_q [2**AddrWidth];
  mem_resp_t            resp_q;
  logic                 resp_valid_q;

  // Writes take priority, a pending read just waits a cycle
  assign gnt_o = req_valid_i & ~wr_valid_i;

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  // Array and read register carry data only
  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem_q[wr_i.addr] <= wr_i.data;
    end
    // Read and write never share a cycle since the grant is dropped
    if (gnt_o) begin
      resp_q.data <= mem_q[req_i.addr];
      // Tags ride along so the consumer needs no side channel
      resp_q.op   <= req_i.op;
      resp_q.last <= req_i.last;
    end
  end

  // Response strobe follows each grant by exactly one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= gnt_o;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/burst_reader.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Takes one command at a time and only while idle
// Addresses wrap at the top of the 256-word space
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module burst_reader (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  burst_pkg::burst_cmd_t cmd_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  output burst_pkg::mem_req_t   req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i
);
  import burst_pkg::*;

  typedef enum logic {
    READ_IDLE,
    READ_ISSUE
  } read_state_e;

  read_state_e          state_q;
  logic [AddrWidth-1:0] addr_q;
  // Words left after the current one
  logic [LenWidth-1:0]  remain_q;
  burst_op_e            op_q;
  logic                 cmd_fire;
  logic                 req_fire;

  assign cmd_ready_o = (state_q == READ_IDLE);
  assign req_valid_o = (state_q == READ_ISSUE);

  assign cmd_fire = cmd_valid_i & cmd_ready_o;
  assign req_fire = req_valid_o & req_ready_i;

  // The request is built from registers only, so it holds while stalled
  assign req_o = '{addr: addr_q, op: op_q, last: (remain_q == '0)};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= READ_IDLE;
      addr_q   <= '0;
      remain_q <= '0;
      op_q     <= OP_SUM;
    end else begin
      case (state_q)
        READ_IDLE: begin
          // Latch the whole command, first request goes out next cycle
          if (cmd_fire) begin
            state_q  <= READ_ISSUE;
            addr_q   <= cmd_i.base;
            remain_q <= cmd_i.len_m1;
            op_q     <= cmd_i.op;
          end
        end
        READ_ISSUE: begin
          if (req_fire) begin
            if (remain_q == '0) begin
              state_q <= READ_IDLE;
            end else begin
              // Plain increment, which wraps from 255 to 0
              addr_q   <= addr_q + 1'b1;
              remain_q <= remain_q - 1'b1;
            end
          end
        end
        default: state_q <= READ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_to_stream.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Memory must answer every granted request exactly once, in order
// At most BufDepth requests are in flight or buffered at any time
// BufDepth below 1 stops elaboration
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mem_to_stream #(
  parameter int unsigned BufDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  burst_pkg::mem_req_t  req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output burst_pkg::mem_resp_t resp_o,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output burst_pkg::mem_req_t  mem_req_o,
  output logic                 mem_req_valid_o,
  input  logic                 mem_gnt_i,
  input  burst_pkg::mem_resp_t mem_resp_i,
  input  logic                 mem_resp_valid_i
);

  typedef logic [$clog2(BufDepth+1)-1:0] credit_t;

  // Free buffer slots not yet claimed by a granted request
  credit_t credit_q;
  logic    buf_ready;
  logic    has_room;
  logic    req_fire;
  logic    resp_fire;

  if (BufDepth < 1) begin : gen_depth_check
    $fatal(1, "mem_to_stream needs BufDepth of at least 1");
  end

  stream_fifo #(
    .Depth (BufDepth)
  ) i_resp_buf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (mem_resp_i),
    .valid_i (mem_resp_valid_i),
    .ready_o (buf_ready),
    .data_o  (resp_o),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i)
  );

  // A slot is reserved at the grant, so the response one cycle later always fits
  assign has_room = buf_ready & (credit_q != '0);

  assign mem_req_o       = req_i;
  assign mem_req_valid_o = req_valid_i & has_room;
  assign req_ready_o     = mem_gnt_i & has_room;

  assign req_fire  = mem_req_valid_o & mem_gnt_i;
  assign resp_fire = resp_valid_o & resp_ready_i;

  // A slot returns once its beat leaves the buffer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= credit_t'(BufDepth);
    end else if (req_fire && !resp_fire) begin
      credit_q <= credit_q - 1'b1;
    end else if (resp_fire && !req_fire) begin
      credit_q <= credit_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Fall-through FIFO for response beats, Depth must be at least 1
// An empty FIFO forwards data_i to data_o in the same cycle
// ready_o only depends on the fill level, never on ready_i
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module stream_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  burst_pkg::mem_resp_t data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output burst_pkg::mem_resp_t data_o,
  output logic                 valid_o,
  input  logic                 ready_i
);
  import burst_pkg::*;

  // A single-entry FIFO still needs a one-bit pointer
  typedef logic [(Depth > 1 ? $clog2(Depth) : 1)-1:0] ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] count_t;

  mem_resp_t storage_q [Depth];
  ptr_t      rd_ptr_q;
  ptr_t      wr_ptr_q;
  count_t    count_q;
  logic      empty;
  logic      full;
  logic      push;
  logic      pop;
  logic      store;
  logic      drain;

  // Advance a pointer and wrap after the last entry
  function automatic ptr_t ptr_next(input ptr_t ptr);
    ptr_next = (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count_q == '0);
  assign full  = (count_q == count_t'(Depth));

  assign ready_o = ~full;

  // When empty the input beat is visible right away
  assign valid_o = ~empty | valid_i;
  assign data_o  = empty ? data_i : storage_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // A beat that passes straight through an empty FIFO is never stored
  assign store = push & ~(empty & pop);
  // Only a pop of a stored entry moves the read side
  assign drain = pop & ~empty;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (store) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (drain) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      count_q <= count_q + count_t'(store) - count_t'(drain);
    end
  end

  // Entry storage holds payload only
  always_ff @(posedge clk_i) begin
    if (store) begin
      storage_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/burst_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Widths are fixed for a single 256-word memory bank
// Burst lengths are carried as length minus one, so 1 to 256 words
// Opcode value 3 is unused and folds like a plain copy
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package burst_pkg;

  // Memory word and address widths
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 8;

  // Burst length field, stored as length minus one
  localparam int unsigned LenWidth = 8;

  // Word count of a finished burst needs one more bit to hold 256
  localparam int unsigned CountWidth = LenWidth + 1;

  // Reduction applied across the words of one burst
  typedef enum logic [1:0] {
    OP_SUM = 2'd0,
    OP_XOR = 2'd1,
    OP_MAX = 2'd2
  } burst_op_e;

  // Burst command as seen on the command input
  typedef struct packed {
    burst_op_e            op;
    logic [AddrWidth-1:0] base;
    logic [LenWidth-1:0]  len_m1;
  } burst_cmd_t;

  // One word read request, tagged with the burst opcode and end marker
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    burst_op_e            op;
    logic                 last;
  } mem_req_t;

  // Read data with the request tags echoed back
  typedef struct packed {
    logic [DataWidth-1:0] data;
    burst_op_e            op;
    logic                 last;
  } mem_resp_t;

  // Reduced value of one burst together with its word count
  typedef struct packed {
    burst_op_e             op;
    logic [DataWidth-1:0]  value;
    logic [CountWidth-1:0] count;
  } burst_result_t;

  // Preload write, no back-pressure
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
  } wr_req_t;

endpackage

`default_nettype wire
